/* design/core_pkg.sv */
package core_pkg;

    localparam int WORD_W    = 16;
    localparam int REG_COUNT = 8;
    localparam int REG_SEL_W = 3;
    localparam int OPCODE_W  = 7;
    // Low bits of the right operand that form a shift amount
    localparam int SHAMT_W   = 4;

    // Bit positions inside flags_t
    localparam int FLAG_Z = 0;
    localparam int FLAG_C = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [WORD_W-1:0]    instr_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    typedef logic [REG_COUNT-1:0] rf_we_t;
    typedef logic [3:0]           flags_t;

    typedef enum logic [OPCODE_W-1:0] {
        OPC_NOP = 7'h00,
        OPC_MOV = 7'h01,
        OPC_LDI = 7'h04,
        OPC_ADD = 7'h07,
        OPC_ADI = 7'h08,
        OPC_SUB = 7'h0a,
        OPC_CMP = 7'h0c,
        OPC_CMI = 7'h0d,
        OPC_AND = 7'h13,
        OPC_ORR = 7'h14,
        OPC_XOR = 7'h15,
        OPC_ANI = 7'h16,
        OPC_ORI = 7'h17,
        OPC_XOI = 7'h18,
        OPC_SHL = 7'h19,
        OPC_SHR = 7'h1a,
        OPC_SLI = 7'h23,
        OPC_SRI = 7'h24,
        OPC_SAR = 7'h25,
        OPC_SAI = 7'h26
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_L_PASS,
        ALU_R_PASS,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_ASHR
    } alu_mode_e;

endpackage

/* design/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder (
    input  core_pkg::instr_t    i_instr,
    output core_pkg::alu_mode_e o_alu_mode,
    output logic                o_r_bus_imm,
    output core_pkg::reg_sel_t  o_l_reg_sel,
    output core_pkg::reg_sel_t  o_r_reg_sel,
    output core_pkg::rf_we_t    o_rf_we,
    output logic                o_flags_we
);
    import core_pkg::*;

    logic [OPCODE_W-1:0] opcode;
    reg_sel_t            reg_dst;
    reg_sel_t            reg_st;
    reg_sel_t            reg_nd;

    assign opcode  = i_instr[OPCODE_W-1:0];
    assign reg_dst = i_instr[9:7];
    assign reg_st  = i_instr[12:10];
    assign reg_nd  = i_instr[15:13];

    // Operand routing and enables
    always_comb begin
        o_r_bus_imm = 1'b0;
        o_l_reg_sel = '0;
        o_r_reg_sel = '0;
        o_rf_we     = '0;
        o_flags_we  = 1'b0;

        case (opcode)
            OPC_MOV: begin
                o_l_reg_sel      = reg_st;
                o_rf_we[reg_dst] = 1'b1;
            end
            OPC_LDI: begin
                o_r_bus_imm      = 1'b1;
                o_rf_we[reg_dst] = 1'b1;
            end
            OPC_ADD, OPC_SUB, OPC_AND, OPC_ORR, OPC_XOR, OPC_SHL, OPC_SHR, OPC_SAR: begin
                o_l_reg_sel      = reg_st;
                o_r_reg_sel      = reg_nd;
                o_rf_we[reg_dst] = 1'b1;
                o_flags_we       = 1'b1;
            end
            OPC_ADI, OPC_ANI, OPC_ORI, OPC_XOI, OPC_SLI, OPC_SRI, OPC_SAI: begin
                o_l_reg_sel      = reg_st;
                o_r_bus_imm      = 1'b1;
                o_rf_we[reg_dst] = 1'b1;
                o_flags_we       = 1'b1;
            end
            // Compares only touch the flags
            OPC_CMP: begin
                o_l_reg_sel = reg_st;
                o_r_reg_sel = reg_nd;
                o_flags_we  = 1'b1;
            end
            OPC_CMI: begin
                o_l_reg_sel = reg_st;
                o_r_bus_imm = 1'b1;
                o_flags_we  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ALU operation per opcode
    always_comb begin
        case (opcode)
            OPC_LDI:                   o_alu_mode = ALU_R_PASS;
            OPC_ADD, OPC_ADI:          o_alu_mode = ALU_ADD;
            OPC_SUB, OPC_CMP, OPC_CMI: o_alu_mode = ALU_SUB;
            OPC_AND, OPC_ANI:          o_alu_mode = ALU_AND;
            OPC_ORR, OPC_ORI:          o_alu_mode = ALU_OR;
            OPC_XOR, OPC_XOI:          o_alu_mode = ALU_XOR;
            OPC_SHL, OPC_SLI:          o_alu_mode = ALU_SHL;
            OPC_SHR, OPC_SRI:          o_alu_mode = ALU_SHR;
            OPC_SAR, OPC_SAI:          o_alu_mode = ALU_ASHR;
            default:                   o_alu_mode = ALU_L_PASS;
        endcase
    end

endmodule

/* design/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                i_clk,
    input  logic                i_rst,
    input  core_pkg::instr_t    i_instr,
    input  core_pkg::word_t     i_imm,
    input  logic                i_submit,
    input  logic                i_next_ready,
    input  logic                i_flush,
    output logic                o_ready,
    output logic                o_dec_submit,
    output core_pkg::word_t     o_imm,
    output core_pkg::alu_mode_e o_alu_mode,
    output logic                o_r_bus_imm,
    output core_pkg::reg_sel_t  o_l_reg_sel,
    output core_pkg::reg_sel_t  o_r_reg_sel,
    output core_pkg::rf_we_t    o_rf_we,
    output logic                o_flags_we
);
    import core_pkg::*;

    logic      buf_valid;
    instr_t    buf_instr;
    word_t     buf_imm;
    instr_t    cur_instr;
    word_t     cur_imm;
    logic      fire;
    logic      park;
    alu_mode_e c_alu_mode;
    logic      c_r_bus_imm;
    reg_sel_t  c_l_reg_sel;
    reg_sel_t  c_r_reg_sel;
    rf_we_t    c_rf_we;
    logic      c_flags_we;

    // Combinational so the source sees it in the same cycle
    assign o_ready = i_next_ready & ~buf_valid;

    // A parked instruction goes out before anything new
    assign cur_instr = buf_valid ? buf_instr : i_instr;
    assign cur_imm   = buf_valid ? buf_imm : i_imm;

    assign fire = i_next_ready & (i_submit | buf_valid) & ~i_flush;
    assign park = i_submit & ~i_next_ready & ~buf_valid & ~i_flush;

    instr_decoder u_decoder (
        .i_instr     (cur_instr),
        .o_alu_mode  (c_alu_mode),
        .o_r_bus_imm (c_r_bus_imm),
        .o_l_reg_sel (c_l_reg_sel),
        .o_r_reg_sel (c_r_reg_sel),
        .o_rf_we     (c_rf_we),
        .o_flags_we  (c_flags_we)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            buf_valid    <= 1'b0;
            o_dec_submit <= 1'b0;
            o_alu_mode   <= ALU_L_PASS;
            o_r_bus_imm  <= 1'b0;
            o_l_reg_sel  <= '0;
            o_r_reg_sel  <= '0;
            o_rf_we      <= '0;
            o_flags_we   <= 1'b0;
        end else begin
            o_dec_submit <= fire;
            if (fire || i_flush) begin
                buf_valid <= 1'b0;
            end else if (park) begin
                buf_valid <= 1'b1;
            end
            if (fire) begin
                o_alu_mode  <= c_alu_mode;
                o_r_bus_imm <= c_r_bus_imm;
                o_l_reg_sel <= c_l_reg_sel;
                o_r_reg_sel <= c_r_reg_sel;
                o_rf_we     <= c_rf_we;
                o_flags_we  <= c_flags_we;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (park) begin
            buf_instr <= i_instr;
            buf_imm   <= i_imm;
        end
        if (fire) begin
            o_imm <= cur_imm;
        end
    end

endmodule

/* design/execute_stage.sv */
`timescale 1ns/10ps

module execute_stage (
    input  logic                i_dec_submit,
    input  core_pkg::word_t     i_imm,
    input  core_pkg::alu_mode_e i_alu_mode,
    input  logic                i_r_bus_imm,
    input  core_pkg::reg_sel_t  i_l_reg_sel,
    input  core_pkg::reg_sel_t  i_r_reg_sel,
    input  core_pkg::rf_we_t    i_rf_we,
    input  logic                i_flags_we,
    input  core_pkg::word_t     i_l_data,
    input  core_pkg::word_t     i_r_data,
    input  core_pkg::flags_t    i_flags,
    output core_pkg::reg_sel_t  o_l_sel,
    output core_pkg::reg_sel_t  o_r_sel,
    output logic                o_res_valid,
    output core_pkg::word_t     o_res_data,
    output core_pkg::rf_we_t    o_res_rf_we,
    output logic                o_res_flags_we,
    output core_pkg::flags_t    o_res_flags
);
    import core_pkg::*;

    word_t              r_opnd;
    logic [SHAMT_W-1:0] shamt;
    logic [WORD_W:0]    sum;
    logic [WORD_W:0]    diff;
    word_t              result;
    logic               carry;
    logic               ovf;

    assign o_l_sel = i_l_reg_sel;
    assign o_r_sel = i_r_reg_sel;

    assign r_opnd = i_r_bus_imm ? i_imm : i_r_data;
    assign shamt  = r_opnd[SHAMT_W-1:0];
    assign sum    = {1'b0, i_l_data} + {1'b0, r_opnd};
    // Top bit is the borrow
    assign diff   = {1'b0, i_l_data} - {1'b0, r_opnd};

    always_comb begin
        result = i_l_data;
        carry  = 1'b0;
        ovf    = 1'b0;
        case (i_alu_mode)
            ALU_L_PASS: result = i_l_data;
            ALU_R_PASS: result = r_opnd;
            ALU_ADD: begin
                result = sum[WORD_W-1:0];
                carry  = sum[WORD_W];
                ovf    = (i_l_data[WORD_W-1] == r_opnd[WORD_W-1]) &&
                         (result[WORD_W-1] != i_l_data[WORD_W-1]);
            end
            ALU_SUB: begin
                result = diff[WORD_W-1:0];
                carry  = diff[WORD_W];
                ovf    = (i_l_data[WORD_W-1] != r_opnd[WORD_W-1]) &&
                         (result[WORD_W-1] != i_l_data[WORD_W-1]);
            end
            ALU_AND:  result = i_l_data & r_opnd;
            ALU_OR:   result = i_l_data | r_opnd;
            ALU_XOR:  result = i_l_data ^ r_opnd;
            ALU_SHL:  result = i_l_data << shamt;
            ALU_SHR:  result = i_l_data >> shamt;
            ALU_ASHR: result = word_t'($signed(i_l_data) >>> shamt);
            default:  result = i_l_data;
        endcase
    end

    // Flags not updated by this op keep their current value
    always_comb begin
        o_res_flags = i_flags;
        if (i_flags_we) begin
            o_res_flags[FLAG_Z] = (result == '0);
            o_res_flags[FLAG_C] = carry;
            o_res_flags[FLAG_N] = result[WORD_W-1];
            o_res_flags[FLAG_V] = ovf;
        end
    end

    assign o_res_data     = result;
    assign o_res_valid    = i_dec_submit;
    assign o_res_rf_we    = i_dec_submit ? i_rf_we : '0;
    assign o_res_flags_we = i_dec_submit & i_flags_we;

endmodule

/* design/result_stage.sv */
`timescale 1ns/10ps

module result_stage (
    input  logic               i_clk,
    input  logic               i_rst,
    input  core_pkg::reg_sel_t i_l_sel,
    input  core_pkg::reg_sel_t i_r_sel,
    input  logic               i_res_valid,
    input  core_pkg::word_t    i_res_data,
    input  core_pkg::rf_we_t   i_res_rf_we,
    input  logic               i_res_flags_we,
    input  core_pkg::flags_t   i_res_flags,
    output core_pkg::word_t    o_l_data,
    output core_pkg::word_t    o_r_data,
    output core_pkg::flags_t   o_flags,
    output logic               o_retire,
    output logic               o_wb_we,
    output core_pkg::reg_sel_t o_wb_reg,
    output core_pkg::word_t    o_wb_data
);
    import core_pkg::*;

    word_t    regs [REG_COUNT];
    flags_t   flags_q;
    reg_sel_t wb_idx;

    assign o_l_data = regs[i_l_sel];
    assign o_r_data = regs[i_r_sel];
    assign o_flags  = flags_q;

    // One-hot enable to register number
    always_comb begin
        wb_idx = '0;
        for (int i = 0; i < REG_COUNT; i++) begin
            if (i_res_rf_we[i]) begin
                wb_idx = reg_sel_t'(i);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            flags_q  <= '0;
            o_retire <= 1'b0;
            o_wb_we  <= 1'b0;
        end else begin
            for (int i = 0; i < REG_COUNT; i++) begin
                if (i_res_valid && i_res_rf_we[i]) begin
                    regs[i] <= i_res_data;
                end
            end
            if (i_res_valid && i_res_flags_we) begin
                flags_q <= i_res_flags;
            end
            o_retire <= i_res_valid;
            o_wb_we  <= i_res_valid & (|i_res_rf_we);
        end
    end

    always_ff @(posedge i_clk) begin
        o_wb_reg  <= wb_idx;
        o_wb_data <= i_res_data;
    end

endmodule

/* design/core_top.sv */
`timescale 1ns/10ps

module core_top (
    input  logic               i_clk,
    input  logic               i_rst,
    input  core_pkg::instr_t   i_instr,
    input  core_pkg::word_t    i_imm,
    input  logic               i_submit,
    input  logic               i_flush,
    input  logic               i_hold,
    output logic               o_ready,
    output logic               o_retire,
    output logic               o_wb_we,
    output core_pkg::reg_sel_t o_wb_reg,
    output core_pkg::word_t    o_wb_data,
    output core_pkg::flags_t   o_flags
);
    import core_pkg::*;

    logic      dec_submit;
    word_t     dec_imm;
    alu_mode_e dec_alu_mode;
    logic      dec_r_bus_imm;
    reg_sel_t  dec_l_reg_sel;
    reg_sel_t  dec_r_reg_sel;
    rf_we_t    dec_rf_we;
    logic      dec_flags_we;
    reg_sel_t  rd_l_sel;
    reg_sel_t  rd_r_sel;
    word_t     rd_l_data;
    word_t     rd_r_data;
    logic      res_valid;
    word_t     res_data;
    rf_we_t    res_rf_we;
    logic      res_flags_we;
    flags_t    res_flags;

    decode_stage u_decode (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_instr      (i_instr),
        .i_imm        (i_imm),
        .i_submit     (i_submit),
        .i_next_ready (~i_hold),
        .i_flush      (i_flush),
        .o_ready      (o_ready),
        .o_dec_submit (dec_submit),
        .o_imm        (dec_imm),
        .o_alu_mode   (dec_alu_mode),
        .o_r_bus_imm  (dec_r_bus_imm),
        .o_l_reg_sel  (dec_l_reg_sel),
        .o_r_reg_sel  (dec_r_reg_sel),
        .o_rf_we      (dec_rf_we),
        .o_flags_we   (dec_flags_we)
    );

    execute_stage u_execute (
        .i_dec_submit   (dec_submit),
        .i_imm          (dec_imm),
        .i_alu_mode     (dec_alu_mode),
        .i_r_bus_imm    (dec_r_bus_imm),
        .i_l_reg_sel    (dec_l_reg_sel),
        .i_r_reg_sel    (dec_r_reg_sel),
        .i_rf_we        (dec_rf_we),
        .i_flags_we     (dec_flags_we),
        .i_l_data       (rd_l_data),
        .i_r_data       (rd_r_data),
        .i_flags        (o_flags),
        .o_l_sel        (rd_l_sel),
        .o_r_sel        (rd_r_sel),
        .o_res_valid    (res_valid),
        .o_res_data     (res_data),
        .o_res_rf_we    (res_rf_we),
        .o_res_flags_we (res_flags_we),
        .o_res_flags    (res_flags)
    );

    result_stage u_result (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_l_sel        (rd_l_sel),
        .i_r_sel        (rd_r_sel),
        .i_res_valid    (res_valid),
        .i_res_data     (res_data),
        .i_res_rf_we    (res_rf_we),
        .i_res_flags_we (res_flags_we),
        .i_res_flags    (res_flags),
        .o_l_data       (rd_l_data),
        .o_r_data       (rd_r_data),
        .o_flags        (o_flags),
        .o_retire       (o_retire),
        .o_wb_we        (o_wb_we),
        .o_wb_reg       (o_wb_reg),
        .o_wb_data      (o_wb_data)
    );

endmodule

/* verif/core_props.sv */
`timescale 1ns/10ps

module core_props (
    input logic i_clk,
    input logic i_rst,
    input logic i_submit,
    input logic i_flush,
    input logic i_hold,
    input logic i_ready,
    input logic i_retire,
    input logic i_wb_we
);

    // Retire is registered, so it stays low on the first cycle out of reset
    retire_after_reset: assert property (@(posedge i_clk) $fell(i_rst) |-> !i_retire)
        else $error("o_retire high in the cycle after reset");

    wb_we_needs_retire: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_we |-> i_retire)
        else $error("o_wb_we high without o_retire");

    hold_blocks_ready: assert property (@(posedge i_clk) i_hold |-> !i_ready)
        else $error("o_ready high while i_hold is high");

    // Direct acceptance goes through decode and result in two edges
    accept_to_retire: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_submit && i_ready && !i_flush) |-> ##2 i_retire)
        else $error("accepted instruction did not retire two cycles later");

endmodule

bind core_top core_props u_props (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_submit (i_submit),
    .i_flush  (i_flush),
    .i_hold   (i_hold),
    .i_ready  (o_ready),
    .i_retire (o_retire),
    .i_wb_we  (o_wb_we)
);

/* verif/core_tb.sv */
`timescale 1ns/10ps

module core_tb;
    import core_pkg::*;

    localparam int N_ENTRIES   = 27;
    localparam int PASSES      = 2;
    localparam int CYCLE_LIMIT = 40 * PASSES * N_ENTRIES + 50;

    logic     i_clk;
    logic     i_rst;
    instr_t   i_instr;
    word_t    i_imm;
    logic     i_submit;
    logic     i_flush;
    logic     i_hold;
    logic     o_ready;
    logic     o_retire;
    logic     o_wb_we;
    reg_sel_t o_wb_reg;
    word_t    o_wb_data;
    flags_t   o_flags;

    // Table of stimulus and expected results
    string    t_name  [N_ENTRIES];
    instr_t   t_instr [N_ENTRIES];
    word_t    t_imm   [N_ENTRIES];
    bit       t_flush [N_ENTRIES];
    bit       t_we    [N_ENTRIES];
    reg_sel_t t_reg   [N_ENTRIES];
    word_t    t_data  [N_ENTRIES];
    flags_t   t_flags [N_ENTRIES];

    int n_added;
    int keep_count;
    int err_count;
    int exp_ptr;
    int pass_retired;
    int total_retired;
    int cycle_count;
    bit buf_full;

    core_top dut0 (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_instr   (i_instr),
        .i_imm     (i_imm),
        .i_submit  (i_submit),
        .i_flush   (i_flush),
        .i_hold    (i_hold),
        .o_ready   (o_ready),
        .o_retire  (o_retire),
        .o_wb_we   (o_wb_we),
        .o_wb_reg  (o_wb_reg),
        .o_wb_data (o_wb_data),
        .o_flags   (o_flags)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // Fields: opcode 6..0, rd 9..7, rs1 12..10, rs2 15..13
    function automatic instr_t encode(opcode_e op, int rd, int rs1, int rs2);
        encode = {reg_sel_t'(rs2), reg_sel_t'(rs1), reg_sel_t'(rd), op};
    endfunction

    task automatic add_entry(input string name, input opcode_e op, input int rd,
                             input int rs1, input int rs2, input word_t imm,
                             input bit flush, input bit we, input int rg,
                             input word_t data, input flags_t flags);
        t_name[n_added]  = name;
        t_instr[n_added] = encode(op, rd, rs1, rs2);
        t_imm[n_added]   = imm;
        t_flush[n_added] = flush;
        t_we[n_added]    = we;
        t_reg[n_added]   = reg_sel_t'(rg);
        t_data[n_added]  = data;
        t_flags[n_added] = flags;
        if (!flush) begin
            keep_count++;
        end
        n_added++;
    endtask

    // Flags column is {overflow, negative, carry, zero}
    task automatic build_table();
        add_entry("ldi_r1",      OPC_LDI, 1, 0, 0, 16'h7ff0, 0, 1, 1, 16'h7ff0, 4'b0000);
        add_entry("mov_r2",      OPC_MOV, 2, 1, 0, 16'h0000, 0, 1, 2, 16'h7ff0, 4'b0000);
        add_entry("ldi_r3",      OPC_LDI, 3, 0, 0, 16'h0020, 0, 1, 3, 16'h0020, 4'b0000);
        add_entry("add_ovf",     OPC_ADD, 4, 1, 3, 16'h0000, 0, 1, 4, 16'h8010, 4'b1100);
        add_entry("sub_ovf",     OPC_SUB, 5, 4, 2, 16'h0000, 0, 1, 5, 16'h0020, 4'b1000);
        add_entry("and_zero",    OPC_AND, 6, 5, 4, 16'h0000, 0, 1, 6, 16'h0000, 4'b0001);
        add_entry("orr_dep",     OPC_ORR, 6, 6, 4, 16'h0000, 0, 1, 6, 16'h8010, 4'b0100);
        add_entry("xor_dep",     OPC_XOR, 7, 6, 1, 16'h0000, 0, 1, 7, 16'hffe0, 4'b0100);
        add_entry("add_carry",   OPC_ADD, 5, 7, 6, 16'h0000, 0, 1, 5, 16'h7ff0, 4'b1010);
        add_entry("sub_borrow",  OPC_SUB, 4, 3, 1, 16'h0000, 0, 1, 4, 16'h8030, 4'b0110);
        add_entry("adi",         OPC_ADI, 2, 3, 0, 16'h0fe0, 0, 1, 2, 16'h1000, 4'b0000);
        add_entry("ani",         OPC_ANI, 3, 7, 0, 16'h0ff0, 0, 1, 3, 16'h0fe0, 4'b0000);
        add_entry("ori",         OPC_ORI, 3, 3, 0, 16'h000f, 0, 1, 3, 16'h0fef, 4'b0000);
        add_entry("xoi",         OPC_XOI, 3, 3, 0, 16'hffff, 0, 1, 3, 16'hf010, 4'b0100);
        add_entry("ldi_shamt",   OPC_LDI, 0, 0, 0, 16'h0013, 0, 1, 0, 16'h0013, 4'b0100);
        add_entry("shl",         OPC_SHL, 2, 3, 0, 16'h0000, 0, 1, 2, 16'h8080, 4'b0100);
        add_entry("shr",         OPC_SHR, 4, 3, 0, 16'h0000, 0, 1, 4, 16'h1e02, 4'b0000);
        add_entry("sar",         OPC_SAR, 5, 3, 0, 16'h0000, 0, 1, 5, 16'hfe02, 4'b0100);
        add_entry("sli",         OPC_SLI, 6, 1, 0, 16'h0024, 0, 1, 6, 16'hff00, 4'b0100);
        add_entry("sri",         OPC_SRI, 7, 6, 0, 16'hfff8, 0, 1, 7, 16'h00ff, 4'b0000);
        add_entry("sai",         OPC_SAI, 7, 5, 0, 16'h001f, 0, 1, 7, 16'hffff, 4'b0100);
        add_entry("cmp_eq",      OPC_CMP, 0, 1, 1, 16'h0000, 0, 0, 0, 16'h0000, 4'b0001);
        add_entry("cmi_lt",      OPC_CMI, 0, 4, 0, 16'h1e03, 0, 0, 0, 16'h0000, 4'b0110);
        add_entry("nop",         OPC_NOP, 0, 0, 0, 16'h0000, 0, 0, 0, 16'h0000, 4'b0110);
        add_entry("ldi_flushed", OPC_LDI, 1, 0, 0, 16'hdead, 1, 0, 0, 16'h0000, 4'b0000);
        add_entry("mov_after",   OPC_MOV, 0, 1, 0, 16'h0000, 0, 1, 0, 16'h7ff0, 4'b0110);
        add_entry("add_final",   OPC_ADD, 2, 0, 1, 16'h0000, 0, 1, 2, 16'hffe0, 4'b1100);
    endtask

    task automatic check(input string name, input logic [15:0] expected,
                         input logic [15:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    // Inputs were set at the falling edge; sample ready, then track the hold buffer
    task automatic step_cycle(input string name, output bit accepted);
        #5;
        check({name, " ready"}, 16'(!i_hold && !buf_full), 16'(o_ready));
        accepted = i_submit && !i_flush && !buf_full;
        if (i_flush || !i_hold) begin
            buf_full = 1'b0;
        end else if (i_submit) begin
            buf_full = 1'b1;
        end
        @(posedge i_clk);
    endtask

    task automatic apply_entry(input int idx, input bit random_hold);
        bit acc;
        acc = 1'b0;
        while (!acc) begin
            @(negedge i_clk);
            i_instr  = t_instr[idx];
            i_imm    = t_imm[idx];
            i_submit = 1'b1;
            i_flush  = 1'b0;
            i_hold   = random_hold ? ($urandom_range(2) == 0) : 1'b0;
            step_cycle(t_name[idx], acc);
        end
    endtask

    task automatic apply_flushed(input int idx, input bit random_hold);
        bit acc;
        // Let any parked instruction go first
        while (buf_full) begin
            @(negedge i_clk);
            i_submit = 1'b0;
            i_flush  = 1'b0;
            i_hold   = 1'b0;
            step_cycle(t_name[idx], acc);
        end
        @(negedge i_clk);
        i_instr  = t_instr[idx];
        i_imm    = t_imm[idx];
        i_submit = 1'b1;
        i_hold   = 1'b1;
        step_cycle(t_name[idx], acc);
        @(negedge i_clk);
        i_submit = 1'b0;
        i_flush  = 1'b1;
        i_hold   = random_hold ? ($urandom_range(2) == 0) : 1'b0;
        step_cycle(t_name[idx], acc);
    endtask

    task automatic run_pass(input int pass_idx, input bit random_hold);
        if (pass_idx != 0) begin
            @(negedge i_clk);
        end
        i_rst    = 1'b1;
        i_submit = 1'b0;
        i_flush  = 1'b0;
        i_hold   = 1'b0;
        repeat (3) @(posedge i_clk);
        exp_ptr      = 0;
        pass_retired = 0;
        buf_full     = 1'b0;
        @(negedge i_clk);
        i_rst = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (t_flush[i]) begin
                apply_flushed(i, random_hold);
            end else begin
                apply_entry(i, random_hold);
            end
        end
        @(negedge i_clk);
        i_submit = 1'b0;
        i_flush  = 1'b0;
        i_hold   = 1'b0;
        while (pass_retired < keep_count) begin
            @(posedge i_clk);
        end
        // Window for any duplicate retire
        repeat (4) @(posedge i_clk);
        check($sformatf("pass%0d retire count", pass_idx), 16'(keep_count), 16'(pass_retired));
    endtask

    // Retires are compared in order against the entries that were not flushed
    always @(negedge i_clk) begin
        if (!i_rst && o_retire) begin
            while (exp_ptr < N_ENTRIES && t_flush[exp_ptr]) begin
                exp_ptr++;
            end
            if (exp_ptr >= N_ENTRIES) begin
                $display("Unexpected retire after the last table entry");
                err_count++;
            end else begin
                check({t_name[exp_ptr], " wb_we"}, 16'(t_we[exp_ptr]), 16'(o_wb_we));
                if (t_we[exp_ptr]) begin
                    check({t_name[exp_ptr], " wb_reg"}, 16'(t_reg[exp_ptr]), 16'(o_wb_reg));
                    check({t_name[exp_ptr], " wb_data"}, t_data[exp_ptr], o_wb_data);
                end
                check({t_name[exp_ptr], " flags"}, 16'(t_flags[exp_ptr]), 16'(o_flags));
                exp_ptr++;
            end
            pass_retired++;
            total_retired++;
        end
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge i_clk);
            cycle_count++;
        end
        $display("Timeout: only %0d of %0d instructions retired before the cycle limit",
                 total_retired, PASSES * keep_count);
        $display("Errors: %0d, retired: %0d", err_count, total_retired);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h69c8_ae33));
        i_rst         = 1'b1;
        i_instr       = '0;
        i_imm         = '0;
        i_submit      = 1'b0;
        i_flush       = 1'b0;
        i_hold        = 1'b0;
        n_added       = 0;
        keep_count    = 0;
        err_count     = 0;
        exp_ptr       = 0;
        pass_retired  = 0;
        total_retired = 0;
        buf_full      = 1'b0;
        build_table();
        run_pass(0, 1'b0);
        run_pass(1, 1'b1);
        $display("Errors: %0d, retired: %0d", err_count, total_retired);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
design/core_pkg.sv
design/instr_decoder.sv
design/decode_stage.sv
design/execute_stage.sv
design/result_stage.sv
design/core_top.sv
verif/core_props.sv
verif/core_tb.sv
